// File: sim.f
verilog/fetch_pkg.sv
verilog/fetch_if.sv
verilog/sync_queue.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/fetch_top.sv
verification/tb_clock.sv
verification/tb_fetch_top.sv

// File: Makefile
TOP := tb_fetch_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

# a $fatal in the testbench gives a nonzero exit status
sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP) -f sim.f
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// File: verification/fetch_testdata.txt
# M address word : instruction memory image, hex, unlisted words are filler
# E pc word      : expected decode output in order, hex
M 0000 003100B3
M 0001 FFF00293
M 0002 40838333
M 0003 0050006F
M 0004 0040006F
M 0008 02A0A513
M 0009 FF90006F
E 0000 003100B3
E 0001 FFF00293
E 0002 40838333
E 0003 0050006F
E 0008 02A0A513
E 0009 FF90006F
E 0002 40838333
E 0003 0050006F
E 0008 02A0A513
E 0009 FF90006F
E 0002 40838333
E 0003 0050006F

// File: verification/tb_fetch_top.sv
//************************************************************
// runs from the project root, reads verification/fetch_testdata.txt
// memory model answers in order after 1 to 4 cycles
//************************************************************
`timescale 1ns/10ps

module tb_fetch_top import fetch_pkg::*; ();

    localparam int SEED = 70634;

    logic                   clk;
    logic                   arst_n;
    logic                   mem_req_valid;
    logic                   mem_req_ready;
    logic [PC_WIDTH-1:0]    mem_req_addr;
    logic                   mem_resp_valid;
    logic [INSTR_WIDTH-1:0] mem_resp_data;
    logic                   dec_valid;
    logic                   dec_ready;
    logic [PC_WIDTH-1:0]    dec_pc;
    logic [6:0]             dec_opcode;
    logic [4:0]             dec_rd;
    logic [4:0]             dec_rs1;
    logic [4:0]             dec_rs2;
    logic [INSTR_WIDTH-1:0] dec_imm;
    logic                   dec_is_r;

    // memory image and expected stream from the data file
    logic [31:0]         mem_image [logic [PC_WIDTH-1:0]];
    logic [PC_WIDTH-1:0] exp_pc [$];
    logic [31:0]         exp_word [$];

    // responses owed by the memory model, oldest first
    logic [31:0] resp_word [$];
    int          resp_due [$];

    int                  cycle = 0;
    int                  limit = 0;
    int                  last_due = 0;
    int                  out_idx = 0;
    int                  pending = 0;
    int                  queued = 0;
    int                  stale = 0;
    logic                first_req_seen = 1'b0;
    logic                last_was_jump = 1'b0;
    logic [PC_WIDTH-1:0] jump_target = '0;

    tb_clock clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fetch_top uut (.*);

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] addr;
        logic [31:0] word;
        fd = $fopen("verification/fetch_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/fetch_testdata.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            tag = line.getc(0);
            if (tag == "M" || tag == "E") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, word);
                if (n != 2) begin
                    $display("malformed line in test data: %s", line);
                    abort_run();
                end
                if (tag == "M") begin
                    mem_image[addr[PC_WIDTH-1:0]] = word;
                end else begin
                    exp_pc.push_back(addr[PC_WIDTH-1:0]);
                    exp_word.push_back(word);
                end
            end
        end
        $fclose(fd);
        if (exp_word.size() == 0) begin
            $display("test data holds no expected output lines");
            abort_run();
        end
    endtask

    task automatic drive_inputs();
        mem_req_ready = ($urandom % 4) != 0;
        dec_ready     = ($urandom % 3) != 0;
        if (resp_word.size() > 0 && resp_due[0] <= cycle) begin
            mem_resp_valid = 1'b1;
            mem_resp_data  = resp_word.pop_front();
            resp_due.delete(0);
        end else begin
            mem_resp_valid = 1'b0;
            mem_resp_data  = '0;
        end
    endtask

    // fields follow the R view for OPC_OP, the I view otherwise
    task automatic check_output();
        logic [31:0] word;
        logic [31:0] imm;
        logic        is_r;
        word = exp_word[out_idx];
        is_r = word[6:0] == OPC_OP;
        imm  = is_r ? 32'd0 : {{20{word[31]}}, word[31:20]};
        if (queued == 0) begin
            $display("decode output at %0t ns with no word left to give", $time);
            abort_run();
        end
        if (last_was_jump) begin
            check_value("dec_pc after jump", 32'(dec_pc), 32'(jump_target));
        end
        check_value("dec_pc", 32'(dec_pc), 32'(exp_pc[out_idx]));
        check_value("dec_opcode", 32'(dec_opcode), 32'(word[6:0]));
        check_value("dec_rd", 32'(dec_rd), 32'(word[11:7]));
        check_value("dec_rs1", 32'(dec_rs1), 32'(word[19:15]));
        check_value("dec_rs2", 32'(dec_rs2), is_r ? 32'(word[24:20]) : 32'd0);
        check_value("dec_imm", dec_imm, imm);
        check_value("dec_is_r", 32'(dec_is_r), 32'(is_r));
        last_was_jump = word[6:0] == OPC_JUMP;
        jump_target   = exp_pc[out_idx] + imm[PC_WIDTH-1:0];
        queued--;
        out_idx++;
    endtask

    // everything that happens at the coming rising edge
    task automatic observe_cycle();
        logic accept;
        logic xfer;
        int   delay;
        accept = mem_req_valid && mem_req_ready;
        xfer   = dec_valid && dec_ready;
        if (xfer) begin
            check_output();
        end
        if (accept) begin
            if (!first_req_seen) begin
                check_value("first mem_req_addr", 32'(mem_req_addr), 32'd0);
            end
            first_req_seen = 1'b1;
            if (mem_image.exists(mem_req_addr)) begin
                resp_word.push_back(mem_image[mem_req_addr]);
            end else begin
                resp_word.push_back({mem_req_addr, 9'd0, 7'h13});
            end
            delay    = 1 + int'($urandom % 4);
            last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1;
            resp_due.push_back(last_due);
            pending++;
        end
        if (mem_resp_valid) begin
            pending--;
        end
        // a jump flushes the queue, every word still owed is stale
        if (xfer && last_was_jump) begin
            queued = 0;
            stale  = pending;
        end else if (mem_resp_valid && stale > 0) begin
            stale--;
        end else if (mem_resp_valid) begin
            queued++;
        end
        if (pending + queued > QUEUE_DEPTH) begin
            $display("at %0t ns %0d requests owed plus %0d queued words exceed the queue depth",
                     $time, pending, queued);
            abort_run();
        end
    endtask

    initial begin
        void'($urandom(SEED));
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        dec_ready      = 1'b0;
        load_testdata();
        limit = 100 + 64 * exp_word.size();
        @(posedge clk);
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            if (arst_n !== 1'b1) begin
                check_value("mem_req_valid in reset", 32'(mem_req_valid), 32'd0);
                check_value("dec_valid in reset", 32'(dec_valid), 32'd0);
            end
        end
        while (out_idx < exp_word.size() && cycle < limit) begin
            @(posedge clk);
            cycle++;
            #2;
            drive_inputs();
            @(negedge clk);
            observe_cycle();
        end
        if (out_idx == exp_word.size()) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("timeout after %0d cycles, %0d of %0d outputs seen",
                     cycle, out_idx, exp_word.size());
            abort_run();
        end
    end

endmodule

// File: verification/tb_clock.sv
//************************************************************
// 40 ns clock, reset low for the first 3 rising edges
//************************************************************
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands just after an edge, like the other inputs
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
    end

endmodule

// File: verilog/fetch_top.sv
//************************************************************
// fetch, queue and decode of the in-order front end
// memory is external, responses in order and never refused
//************************************************************
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,

    // instruction memory
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    output logic [PC_WIDTH-1:0]    mem_req_addr,
    input  logic                   mem_resp_valid,
    input  logic [INSTR_WIDTH-1:0] mem_resp_data,

    // decoded stream
    output logic                   dec_valid,
    input  logic                   dec_ready,
    output logic [PC_WIDTH-1:0]    dec_pc,
    output logic [6:0]             dec_opcode,
    output logic [4:0]             dec_rd,
    output logic [4:0]             dec_rs1,
    output logic [4:0]             dec_rs2,
    output logic [INSTR_WIDTH-1:0] dec_imm,
    output logic                   dec_is_r
);

    logic                   redirect_valid;
    logic [PC_WIDTH-1:0]    redirect_pc;
    logic [QUEUE_WIDTH-1:0] queue_count;

    fetch_if fetch_to_queue ();
    fetch_if queue_to_decode ();

    fetch_unit u_fetch (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .queue_count    (queue_count),
        .q              (fetch_to_queue.source)
    );

    // the redirect pulse doubles as the queue flush
    sync_queue #(
        .WIDTH (QUEUE_WIDTH)
    ) u_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .kill   (redirect_valid),
        .wr     (fetch_to_queue.sink),
        .rd     (queue_to_decode.source),
        .count  (queue_count)
    );

    decode_stage u_decode (
        .clk            (clk),
        .arst_n         (arst_n),
        .q              (queue_to_decode.sink),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready),
        .dec_pc         (dec_pc),
        .dec_opcode     (dec_opcode),
        .dec_rd         (dec_rd),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_imm        (dec_imm),
        .dec_is_r       (dec_is_r)
    );

endmodule

// File: verilog/decode_stage.sv
//************************************************************
// combinational field split of the queue head
// jumps are word relative, only unconditional jumps redirect
//************************************************************
`timescale 1ns/10ps

module decode_stage import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    fetch_if.sink                  q,

    output logic                   redirect_valid,
    output logic [PC_WIDTH-1:0]    redirect_pc,

    output logic                   dec_valid,
    input  logic                   dec_ready,
    output logic [PC_WIDTH-1:0]    dec_pc,
    output logic [6:0]             dec_opcode,
    output logic [4:0]             dec_rd,
    output logic [4:0]             dec_rs1,
    output logic [4:0]             dec_rs2,
    output logic [INSTR_WIDTH-1:0] dec_imm,
    output logic                   dec_is_r
);

    instr_t                 ins;
    logic                   is_r;
    logic                   is_jump;
    logic                   accept;
    logic [INSTR_WIDTH-1:0] imm_ext;

    assign ins     = q.instr;
    assign is_r    = ins.r.opcode == OPC_OP;
    assign is_jump = ins.r.opcode == OPC_JUMP;
    assign imm_ext = {{(INSTR_WIDTH - 12){ins.i.imm[11]}}, ins.i.imm};

    // handshake passes straight through
    assign dec_valid = q.valid;
    assign q.ready   = dec_ready;
    assign accept    = q.valid && dec_ready;

    // opcode, rd and rs1 sit in the same bits for both views
    assign dec_pc     = q.pc;
    assign dec_opcode = ins.r.opcode;
    assign dec_rd     = ins.r.rd;
    assign dec_rs1    = ins.r.rs1;
    assign dec_rs2    = is_r ? ins.r.rs2 : 5'd0;
    assign dec_imm    = is_r ? '0 : imm_ext;
    assign dec_is_r   = is_r;

    // target wraps within the word address space
    assign redirect_valid = accept && is_jump;
    assign redirect_pc    = q.pc + imm_ext[PC_WIDTH-1:0];

    // redirect comes with a transfer and flushes the queue for a cycle
    a_redirect_on_accept: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect_valid |-> (q.valid && q.ready) ##1 !q.valid
    );

endmodule

// File: verilog/fetch_unit.sv
//************************************************************
// issues word fetches under a credit of queue depth
// memory answers in order, at least one cycle after the request
//************************************************************
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,

    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    output logic [PC_WIDTH-1:0]    mem_req_addr,
    input  logic                   mem_resp_valid,
    input  logic [INSTR_WIDTH-1:0] mem_resp_data,

    input  logic                   redirect_valid,
    input  logic [PC_WIDTH-1:0]    redirect_pc,

    input  logic [QUEUE_WIDTH-1:0] queue_count,
    fetch_if.source                q
);

    localparam int FIFO_SIZE = 2 ** QUEUE_WIDTH;

    // address of each outstanding request, oldest at rptr
    logic [PC_WIDTH-1:0]    pc_fifo [FIFO_SIZE];
    logic [QUEUE_WIDTH-1:0] wptr;
    logic [QUEUE_WIDTH-1:0] rptr;

    logic [PC_WIDTH-1:0]    next_pc;
    logic [QUEUE_WIDTH-1:0] stale;
    logic [QUEUE_WIDTH-1:0] inflight;
    logic [QUEUE_WIDTH-1:0] inflight_next;
    logic [QUEUE_WIDTH:0]   used;
    logic                   req_en;
    logic                   req_fire;
    logic                   credit_ok;

    // never more than QUEUE_DEPTH in flight, so the pointer difference is exact
    assign inflight  = wptr - rptr;
    assign used      = {1'b0, inflight} + {1'b0, queue_count};
    assign credit_ok = used < (QUEUE_WIDTH + 1)'(QUEUE_DEPTH);

    assign mem_req_valid = req_en && credit_ok;
    assign mem_req_addr  = next_pc;
    assign req_fire      = mem_req_valid && mem_req_ready;

    // all requests still owed after this edge
    assign inflight_next = inflight + QUEUE_WIDTH'(req_fire) - QUEUE_WIDTH'(mem_resp_valid);

    // credit guarantees the queue has room for every response
    assign q.valid = mem_resp_valid && (stale == '0);
    assign q.pc    = pc_fifo[rptr];
    assign q.instr = mem_resp_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_en  <= 1'b0;
            next_pc <= '0;
            wptr    <= '0;
            rptr    <= '0;
            stale   <= '0;
        end else begin
            req_en <= 1'b1;

            if (req_fire) begin
                wptr <= wptr + 1'b1;
            end
            if (mem_resp_valid) begin
                rptr <= rptr + 1'b1;
            end

            // redirect wins over sequential pc
            if (redirect_valid) begin
                next_pc <= redirect_pc;
            end else if (req_fire) begin
                next_pc <= next_pc + 1'b1;
            end

            // whatever is still owed belongs to the old stream
            if (redirect_valid) begin
                stale <= inflight_next;
            end else if (mem_resp_valid && stale != '0) begin
                stale <= stale - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            pc_fifo[wptr] <= next_pc;
        end
    end

    // requests owed plus queued words stay within the ring
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        used <= (QUEUE_WIDTH + 1)'(QUEUE_DEPTH)
    );

endmodule

// File: verilog/sync_queue.sv
//************************************************************
// ring buffer, 2**WIDTH-1 entries, a written entry shows next cycle
// kill empties it in one cycle and drops a write at the same edge
//************************************************************
`timescale 1ns/10ps

module sync_queue import fetch_pkg::*; #(
    parameter int WIDTH = QUEUE_WIDTH
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             kill,
    fetch_if.sink            wr,
    fetch_if.source          rd,
    output logic [WIDTH-1:0] count
);

    localparam int SIZE = 2 ** WIDTH;

    // payload storage
    logic [PC_WIDTH-1:0] pc_mem [SIZE];
    instr_t              instr_mem [SIZE];

    logic [WIDTH-1:0] head;
    logic [WIDTH-1:0] tail;
    logic             full;
    logic             push;
    logic             pop;

    // one slot stays free to tell full from empty
    assign full  = (tail + 1'b1) == head;
    assign push  = wr.valid && wr.ready;
    assign pop   = rd.valid && rd.ready;
    assign count = tail - head;

    assign wr.ready = !full;
    assign rd.valid = head != tail;
    assign rd.pc    = pc_mem[head];
    assign rd.instr = instr_mem[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
        end else if (kill) begin
            // drop everything, including this cycle's write
            head <= tail;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // slot at tail is free, so writing during a kill is harmless
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[tail]    <= wr.pc;
            instr_mem[tail] <= wr.instr;
        end
    end

    // producer credit must keep writes away from a full ring
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) !(wr.valid && full)
    );

    // head entry stays offered until taken or flushed
    a_rd_valid_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd.valid && !rd.ready && !kill |=> rd.valid
    );

endmodule

// File: verilog/fetch_if.sv
//************************************************************
// valid/ready stream of pc and instruction pairs
// data holds while valid is up unless the stream is killed
//************************************************************
`timescale 1ns/10ps

interface fetch_if import fetch_pkg::*; ();

    logic                valid;
    logic                ready;
    logic [PC_WIDTH-1:0] pc;
    instr_t              instr;

    // producer side
    modport source (
        output valid,
        output pc,
        output instr,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  pc,
        input  instr,
        output ready
    );

endinterface

// File: verilog/fetch_pkg.sv
//************************************************************
// shared widths and opcodes of the fetch front end
// QUEUE_WIDTH must be 2 or more, the queue holds 2**QUEUE_WIDTH-1 words
//************************************************************
package fetch_pkg;

    // word address and instruction sizes
    localparam int PC_WIDTH    = 16;
    localparam int INSTR_WIDTH = 32;

    // queue index width and usable depth
    localparam int QUEUE_WIDTH = 3;
    localparam int QUEUE_DEPTH = (2 ** QUEUE_WIDTH) - 1;

    // opcodes the decode stage tells apart
    localparam logic [6:0] OPC_JUMP = 7'b1101111;
    localparam logic [6:0] OPC_OP   = 7'b0110011;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // immediate layout, low fields shared with r_fmt_t
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one instruction word, two readings
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

endpackage
